//--- bench/sifhTopTb.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module sifhTopTb
    import sifhPkg::*;
();

    // frame geometry
    localparam int samples    = `PIXEL_NUM * `ACQ_NUM;
    localparam int words      = `PIXEL_NUM * `BIN_NUM;
    localparam int rows       = 7;
    localparam int cycleLimit = rows * (samples + words + 20) * 2;
    localparam int cntMax     = (1 << `CNT_BITS) - 1;
    // timestamp distance between neighbouring bins
    localparam int binStep    = 1 << (`NP - `BIN_BITS);

    // stimulus pattern kinds
    localparam logic [2:0] kindFlush  = 3'd0;
    localparam logic [2:0] kindSingle = 3'd1;
    localparam logic [2:0] kindEmpty  = 3'd2;
    localparam logic [2:0] kindAlt    = 3'd3;
    localparam logic [2:0] kindRandom = 3'd4;
    localparam logic [2:0] kindRepeat = 3'd5;

    // one table row per frame
    typedef struct packed {
        logic [2:0]     kind;
        logic [`NP-1:0] base;
        logic [`NP-1:0] spread;
    } row_t;

    logic           clk;
    logic           rstN;
    logic [`NP-1:0] data;
    logic           wrEn;
    logic           peakValid;
    peak_t          peakResult;

    row_t           rowTable [rows];
    logic [`NP-1:0] stim [samples];
    peak_t          expPeak [`PIXEL_NUM];
    int             hist [`PIXEL_NUM][`BIN_NUM];
    integer         seed;
    int             cycleCnt = 0;

    sifhTop u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .data       (data),
        .wrEn       (wrEn),
        .peakValid  (peakValid),
        .peakResult (peakResult)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit from the frame length
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            abortRun($sformatf("timeout after %0d cycles, DUT stopped making progress",
                               cycleCnt));
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic row_t makeRow(input logic [2:0] kind, input logic [`NP-1:0] base,
                                     input logic [`NP-1:0] spread);
        row_t r;
        r.kind   = kind;
        r.base   = base;
        r.spread = spread;
        return r;
    endfunction

    function automatic string kindName(input logic [2:0] kind);
        case (kind)
            kindFlush:  return "flush";
            kindSingle: return "singleBin";
            kindEmpty:  return "noPhoton";
            kindAlt:    return "altBins";
            kindRandom: return "random";
            kindRepeat: return "repeatHits";
            default:    return "unknown";
        endcase
    endfunction

    function automatic string peakText(input peak_t pk);
        return $sformatf("pixel %0d bin %0d count %0d", pk.pixel, pk.bin, pk.count);
    endfunction

    task automatic checkPeak(input string name, input peak_t expected, input peak_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("ERROR %s: expected %s, actual %s", name,
                               peakText(expected), peakText(actual)));
        end
    endtask

    task automatic checkReady(input string name, input int expected, input int actual);
        if (actual != expected) begin
            abortRun($sformatf("ERROR %s: expected %0d accepted samples, actual %0d",
                               name, expected, actual));
        end
    endtask

    task automatic loadTable();
        // bin RAM powers up unknown and this frame's scan clears it
        rowTable[0] = makeRow(kindFlush, '1, '0);
        // bins 1, 4, 7, 10 with 20 hits each so counts saturate
        rowTable[1] = makeRow(kindSingle, `NP'('h045), `NP'('h0C0));
        // also proves the previous frame was cleared
        rowTable[2] = makeRow(kindEmpty, '1, '0);
        // bin pairs 4/5 to 10/11 with 10 hits each and a tie to the lower bin
        rowTable[3] = makeRow(kindAlt, `NP'('h100), `NP'('h080));
        rowTable[4] = makeRow(kindRandom, '0, '0);
        // 8 + 8 + 4 hits on repeated addresses per pixel
        rowTable[5] = makeRow(kindRepeat, `NP'('h020), `NP'('h0C0));
        rowTable[6] = makeRow(kindRandom, '0, '0);
    endtask

    // per-sample timestamps of one frame where sample k is pixel k mod PIXEL_NUM
    task automatic buildStim(input row_t r);
        int             k;
        int             p;
        int             a;
        logic [31:0]    rnd;
        logic [`NP-1:0] ts;
        for (k = 0; k < samples; k++) begin
            p = k % `PIXEL_NUM;
            a = k / `PIXEL_NUM;
            case (r.kind)
                kindSingle: ts = `NP'(int'(r.base) + p * int'(r.spread));
                kindAlt: begin
                    // even acquisitions go one bin higher
                    ts = `NP'(int'(r.base) + p * int'(r.spread) + ((a % 2 == 0) ? binStep : 0));
                end
                kindRepeat: ts = `NP'(int'(r.base) + p * int'(r.spread) + (a / 8) * binStep);
                kindRandom: begin
                    rnd = $random(seed);
                    ts  = rnd[`NP-1:0];
                    // about one in eight is a missed photon
                    if (rnd[15:13] == 3'd0) begin
                        ts = '1;
                    end
                end
                default: ts = '1;
            endcase
            stim[k] = ts;
        end
    endtask

    // reference histogram and peak per pixel
    task automatic predictPeaks();
        int    k;
        int    p;
        int    b;
        int    bin;
        int    best;
        peak_t pk;
        for (p = 0; p < `PIXEL_NUM; p++) begin
            for (b = 0; b < `BIN_NUM; b++) begin
                hist[p][b] = 0;
            end
        end
        for (k = 0; k < samples; k++) begin
            if (stim[k] !== '1) begin
                p   = k % `PIXEL_NUM;
                // each bin spans binStep timestamp codes
                bin = int'(stim[k]) / binStep;
                if (hist[p][bin] < cntMax) begin
                    hist[p][bin]++;
                end
            end
        end
        for (p = 0; p < `PIXEL_NUM; p++) begin
            best = 0;
            // strict compare keeps the lowest bin on a tie
            for (b = 1; b < `BIN_NUM; b++) begin
                if (hist[p][b] > hist[p][best]) begin
                    best = b;
                end
            end
            pk.pixel   = `PIX_BITS'(p);
            pk.bin     = `BIN_BITS'(best);
            pk.count   = `CNT_BITS'(hist[p][best]);
            expPeak[p] = pk;
        end
    endtask

    initial begin
        int    r;
        int    taken;
        int    got;
        string name;
        seed = 68;
        rstN = 1'b0;
        data = '0;
        loadTable();
        // reset held for three rising edges
        repeat (3) begin
            @(negedge clk);
            if (wrEn !== 1'b0 || peakValid !== 1'b0) begin
                abortRun("wrEn or peakValid is not low while reset is held");
            end
        end
        rstN = 1'b1;
        for (r = 0; r < rows; r++) begin
            name = $sformatf("row%0d_%s", r, kindName(rowTable[r].kind));
            buildStim(rowTable[r]);
            predictPeaks();
            // frame starts at the next wrEn rise
            while (wrEn !== 1'b1) begin
                @(negedge clk);
            end
            taken = 0;
            while (wrEn === 1'b1) begin
                if (taken < samples) begin
                    data = stim[taken];
                end else begin
                    data = '1;
                end
                taken++;
                @(negedge clk);
            end
            // a real bin 0 hit that must be ignored while wrEn is low
            data = '0;
            checkReady(name, samples, taken);
            got = 0;
            while (got < `PIXEL_NUM) begin
                if (peakValid === 1'b1) begin
                    if (rowTable[r].kind != kindFlush) begin
                        checkPeak(name, expPeak[got], peakResult);
                    end
                    got++;
                end
                if (got < `PIXEL_NUM) begin
                    if (wrEn !== 1'b0) begin
                        abortRun($sformatf("%s: wrEn went high before all peaks were reported",
                                           name));
                    end
                    @(negedge clk);
                end
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- hw/binRam.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module binRam
    import sifhPkg::*;
(
    input  logic                 clk,
    input  ramWr_t               wr,
    input  logic                 rEnable,
    input  binAddr_t             raddr,
    output logic [`CNT_BITS-1:0] counts
);

    // one word per pixel and bin
    localparam int depth = 1 << `RAM_ADDR;

    logic [`CNT_BITS-1:0] mem [0:depth-1];

    // write port A
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port B, registered
    // same-address read and write gives the old word
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

//--- hw/binUpdate.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module binUpdate
    import sifhPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  sample_t              sample,
    input  logic [`CNT_BITS-1:0] counts,
    output binAddr_t             raddr,
    output logic                 rEnable,
    output ramWr_t               newCounts
);

    logic                 hit;
    binAddr_t             rdAddr;
    logic                 wrPend;
    binAddr_t             wrAddr;
    ramWr_t               lastWr;
    logic [`CNT_BITS-1:0] curCount;
    logic [`CNT_BITS-1:0] nextCount;

    // all-ones timestamp marks a missed photon
    assign hit = sample.valid && (sample.timestamp != '1);

    // bin is the timestamp MSBs
    assign rdAddr.pixel = sample.pixel;
    assign rdAddr.bin   = sample.timestamp[`NP-1 -: `BIN_BITS];

    // stage 1, read the current bin count
    assign raddr   = rdAddr;
    assign rEnable = hit;

    // carry the address into the write stage
    always_ff @(posedge clk) begin
        wrAddr <= rdAddr;
        if (!rstN) begin
            wrPend <= 1'b0;
        end else begin
            wrPend <= hit;
        end
    end

    // remember the write that lands this edge
    // RAM still returns the old word for a same-cycle read
    always_ff @(posedge clk) begin
        lastWr.addr <= newCounts.addr;
        lastWr.data <= newCounts.data;
        if (!rstN) begin
            lastWr.en <= 1'b0;
        end else begin
            lastWr.en <= newCounts.en;
        end
    end

    // forward own last write on an address match
    assign curCount = (lastWr.en && (lastWr.addr == wrAddr)) ? lastWr.data : counts;

    // saturating increment
    assign nextCount = (curCount == '1) ? curCount : curCount + 1'b1;

    // stage 2, write back at end of cycle
    assign newCounts.en   = wrPend;
    assign newCounts.addr = wrAddr;
    assign newCounts.data = nextCount;

endmodule

//--- hw/histFsm.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module histFsm
    import sifhPkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic [`NP-1:0]  data,
    output logic            wrEn,
    output sample_t         sample,
    input  binAddr_t        updRaddr,
    input  logic            updREnable,
    input  ramWr_t          updWr,
    output binAddr_t        raddr,
    output logic            rEnable,
    output ramWr_t          ramWr,
    output logic            scanValid,
    output binAddr_t        scanAddr
);

    // acquisition counter width
    localparam int acqW = $clog2(`ACQ_NUM);

    // frame phases
    // wait is the post-reset and post-clear gap before accumulate
    localparam logic [1:0] stWait  = 2'd0;
    localparam logic [1:0] stAcc   = 2'd1;
    localparam logic [1:0] stDrain = 2'd2;
    localparam logic [1:0] stScan  = 2'd3;

    logic [1:0]           state;
    logic [`PIX_BITS-1:0] pixCnt;
    logic [acqW-1:0]      acqCnt;
    logic                 drainCnt;
    binAddr_t             scanCnt;
    logic                 pixLast;
    logic                 acqLast;
    logic                 scanLast;
    logic                 scanning;

    // ready level straight from the phase
    assign wrEn     = (state == stAcc);
    assign scanning = (state == stScan);

    // end-of-row and end-of-frame markers
    assign pixLast  = (pixCnt == `PIX_BITS'(`PIXEL_NUM - 1));
    assign acqLast  = (acqCnt == acqW'(`ACQ_NUM - 1));
    assign scanLast = (scanCnt.pixel == `PIX_BITS'(`PIXEL_NUM - 1)) &&
                      (scanCnt.bin == `BIN_BITS'(`BIN_NUM - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= stWait;
            pixCnt   <= '0;
            acqCnt   <= '0;
            drainCnt <= 1'b0;
            scanCnt  <= '0;
        end else begin
            case (state)
                stWait: begin
                    // one idle cycle, then open the input
                    state <= stAcc;
                end
                stAcc: begin
                    // one sample every cycle, pixels 0..N-1 per acquisition
                    if (pixLast) begin
                        pixCnt <= '0;
                        if (acqLast) begin
                            acqCnt <= '0;
                            state  <= stDrain;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                    end
                end
                stDrain: begin
                    // two cycles so the last read-modify-write lands
                    if (drainCnt) begin
                        drainCnt <= 1'b0;
                        state    <= stScan;
                    end else begin
                        drainCnt <= 1'b1;
                    end
                end
                stScan: begin
                    // walk all words pixel-major, bin-ascending
                    if (scanLast) begin
                        scanCnt <= '0;
                        state   <= stWait;
                    end else begin
                        scanCnt <= binAddr_t'(scanCnt + 1'b1);
                    end
                end
                default: begin
                    state <= stWait;
                end
            endcase
        end
    end

    // tag each accepted timestamp with its pixel
    always_ff @(posedge clk) begin
        sample.pixel     <= pixCnt;
        sample.timestamp <= data;
        if (!rstN) begin
            sample.valid <= 1'b0;
        end else begin
            sample.valid <= wrEn;
        end
    end

    // scan address delayed to meet RAM read data
    always_ff @(posedge clk) begin
        scanAddr <= scanCnt;
        if (!rstN) begin
            scanValid <= 1'b0;
        end else begin
            scanValid <= scanning;
        end
    end

    // read port owner
    // updater outside the scan, scan counter during it
    always_comb begin
        if (scanning) begin
            rEnable = 1'b1;
            raddr   = scanCnt;
        end else begin
            rEnable = updREnable;
            raddr   = updRaddr;
        end
    end

    // write port owner
    // clear writes trail the scan reads by one cycle
    always_comb begin
        if (scanValid) begin
            ramWr.en   = 1'b1;
            ramWr.addr = scanAddr;
            ramWr.data = '0;
        end else begin
            ramWr = updWr;
        end
    end

endmodule

//--- hw/peakFinder.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module peakFinder
    import sifhPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 scanValid,
    input  binAddr_t             scanAddr,
    input  logic [`CNT_BITS-1:0] counts,
    output logic                 peakValid,
    output peak_t                peakResult
);

    logic [`CNT_BITS-1:0] maxCount;
    logic [`BIN_BITS-1:0] maxBin;
    logic [`CNT_BITS-1:0] candCount;
    logic [`BIN_BITS-1:0] candBin;
    logic                 firstBin;
    logic                 lastBin;

    // pixel boundaries in the scan order
    assign firstBin = (scanAddr.bin == '0);
    assign lastBin  = (scanAddr.bin == `BIN_BITS'(`BIN_NUM - 1));

    // best bin so far including this word
    // bin 0 always seeds, later bins only on a strict increase
    always_comb begin
        candCount = maxCount;
        candBin   = maxBin;
        if (firstBin || (counts > maxCount)) begin
            candCount = counts;
            candBin   = scanAddr.bin;
        end
    end

    // running maximum
    always_ff @(posedge clk) begin
        if (scanValid) begin
            maxCount <= candCount;
            maxBin   <= candBin;
        end
    end

    // report payload, captured at the pixel's last bin
    always_ff @(posedge clk) begin
        if (scanValid && lastBin) begin
            peakResult.pixel <= scanAddr.pixel;
            peakResult.bin   <= candBin;
            peakResult.count <= candCount;
        end
    end

    // one pulse per pixel
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanValid && lastBin;
        end
    end

endmodule

//--- hw/sifhParams_defs.svh
`ifndef SIFH_PARAMS_DEFS_SVH
`define SIFH_PARAMS_DEFS_SVH

// timestamp width from the TDC
`define NP 10

// bin index is the top BIN_BITS of a timestamp
`define BIN_BITS 4

// pixel index width
`define PIX_BITS 2

// derived pixel and bin counts
`define PIXEL_NUM (1 << `PIX_BITS)
`define BIN_NUM (1 << `BIN_BITS)

// acquisitions per frame
`define ACQ_NUM 20

// per-bin counter width, saturating
`define CNT_BITS 4

// one RAM word per (pixel, bin)
`define RAM_ADDR (`PIX_BITS + `BIN_BITS)

`endif

//--- hw/sifhPkg.sv
`include "sifhParams_defs.svh"

package sifhPkg;

    // one bin word address, pixel-major
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`BIN_BITS-1:0] bin;
    } binAddr_t;

    // accepted timestamp tagged with its pixel
    typedef struct packed {
        logic                 valid;
        logic [`PIX_BITS-1:0] pixel;
        logic [`NP-1:0]       timestamp;
    } sample_t;

    // single RAM write request
    typedef struct packed {
        logic                 en;
        binAddr_t             addr;
        logic [`CNT_BITS-1:0] data;
    } ramWr_t;

    // peak report for one pixel
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`BIN_BITS-1:0] bin;
        logic [`CNT_BITS-1:0] count;
    } peak_t;

endpackage

//--- hw/sifhTop.sv
`timescale 1ns/1ps
`include "sifhParams_defs.svh"

module sifhTop
    import sifhPkg::*;
(
    input  logic           clk,
    input  logic           rstN,
    input  logic [`NP-1:0] data,
    output logic           wrEn,
    output logic           peakValid,
    output peak_t          peakResult
);

    // controller to updater
    sample_t              sample;

    // updater requests, muxed in the controller
    binAddr_t             updRaddr;
    logic                 updREnable;
    ramWr_t               updWr;

    // RAM ports after the mux
    binAddr_t             raddr;
    logic                 rEnable;
    ramWr_t               ramWr;
    logic [`CNT_BITS-1:0] counts;

    // scan tap toward the peak search
    logic                 scanValid;
    binAddr_t             scanAddr;

    histFsm u_histFsm (
        .clk        (clk),
        .rstN       (rstN),
        .data       (data),
        .wrEn       (wrEn),
        .sample     (sample),
        .updRaddr   (updRaddr),
        .updREnable (updREnable),
        .updWr      (updWr),
        .raddr      (raddr),
        .rEnable    (rEnable),
        .ramWr      (ramWr),
        .scanValid  (scanValid),
        .scanAddr   (scanAddr)
    );

    binUpdate u_binUpdate (
        .clk       (clk),
        .rstN      (rstN),
        .sample    (sample),
        .counts    (counts),
        .raddr     (updRaddr),
        .rEnable   (updREnable),
        .newCounts (updWr)
    );

    binRam u_binRam (
        .clk     (clk),
        .wr      (ramWr),
        .rEnable (rEnable),
        .raddr   (raddr),
        .counts  (counts)
    );

    peakFinder u_peakFinder (
        .clk        (clk),
        .rstN       (rstN),
        .scanValid  (scanValid),
        .scanAddr   (scanAddr),
        .counts     (counts),
        .peakValid  (peakValid),
        .peakResult (peakResult)
    );

endmodule

//--- sifhTop.f
+incdir+hw
hw/sifhPkg.sv
hw/histFsm.sv
hw/binUpdate.sv
hw/binRam.sv
hw/peakFinder.sv
hw/sifhTop.sv
bench/sifhTopTb.sv
